/* vlog.f */
verilog/pid_types_pkg.sv
verilog/host_regs_pkg.sv
verilog/pid_param_if.sv
verilog/oversample_filter.sv
verilog/pid_param_regs.sv
verilog/pid_core.sv
verilog/pid_lock_top.sv
tb/pid_lock_props.sv
tb/pid_lock_tb.sv

/* Bender.yml */
package:
  name: pid_lock

dependencies: {}

sources:
  - verilog/pid_types_pkg.sv
  - verilog/host_regs_pkg.sv
  - verilog/pid_param_if.sv
  - verilog/oversample_filter.sv
  - verilog/pid_param_regs.sv
  - verilog/pid_core.sv
  - verilog/pid_lock_top.sv
  - target: test
    files:
      - tb/pid_lock_props.sv
      - tb/pid_lock_tb.sv

/* tb/pid_lock_tb.sv */
`default_nettype none

module pid_lock_tb;
	timeunit 1ns;
	timeprecision 100ps;

	import pid_types_pkg::*;
	import host_regs_pkg::*;

	localparam int os_log      = 2;	// dut default
	localparam int n_init      = 4;	// blocks on the reset coefficients
	localparam int n_gate      = 3;	// blocks per gating step
	localparam int n_random    = 24;
	localparam int n_clear     = 3;
	localparam int n_sat       = 65600;	// a little past the rail at full error and i
	localparam int n_blocks    = n_init + 2 * n_gate + n_random + n_clear + 2 * n_sat;
	localparam int watchdog_ns = n_blocks * 4 * 10 + 20000;	// margin for host writes
	localparam longint out_max = (longint'(1) <<< (w_out - 1)) - 1;
	localparam longint out_min = -(longint'(1) <<< (w_out - 1));

	logic        clk_in;
	logic        reset_in;
	adc_sample_t adc_data;
	logic        adc_valid;
	host_addr_t  host_addr;
	host_word_t  host_data;
	logic        host_we;
	logic        update;
	pid_out_t    pid_data;
	logic        pid_valid;

	// model registers in the order setpoint p i d
	coef_t       shadow [4] = '{16'sd0, 16'sd10, 16'sd3, 16'sd0};	// reset values
	coef_t       active [4] = '{16'sd0, 16'sd10, 16'sd3, 16'sd0};
	logic        en = 1'b0;	// update enable
	longint      u_prev = 0;	// history
	longint      e_prev1 = 0;
	longint      e_prev2 = 0;
	int          mean_q [$];	// block means waiting for an output
	int          max_hits = 0;	// outputs held on the upper rail
	int          min_hits = 0;
	logic [31:0] rng_state = 32'd13;

	pid_lock_top dut_i (
		.clk_in   (clk_in),
		.reset_in (reset_in),
		.adc_data (adc_data),
		.adc_valid(adc_valid),
		.host_addr(host_addr),
		.host_data(host_data),
		.host_we  (host_we),
		.update   (update),
		.pid_data (pid_data),
		.pid_valid(pid_valid)
	);

	always #5 clk_in = ~clk_in;	// 10 ns period

	////////////////////////////////////////////////////////////////////////////
	// helpers
	////////////////////////////////////////////////////////////////////////////

	function automatic logic [31:0] next_random();
		logic [31:0] x;
		x = rng_state;
		x = x ^ (x << 13);	// xorshift32
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rng_state = x;
		return x;
	endfunction

	task automatic abort_run();
		$display("*** TEST FAILED ***");
		$fatal(1);
	endtask

	task automatic host_write(input host_addr_t addr, input host_word_t data);
		@(negedge clk_in);
		host_addr = addr;
		host_data = data;
		host_we   = 1'b1;
		@(negedge clk_in);
		host_we = 1'b0;
		if (addr <= addr_d_coef) begin
			shadow[addr] = coef_t'(data);	// setpoint or coefficient
		end else if (addr == addr_update_en) begin
			en = data[update_en_bit];
		end else if (addr == addr_clear) begin
			u_prev  = 0;
			e_prev1 = 0;
			e_prev2 = 0;
		end
	endtask

	task automatic pulse_update();
		@(negedge clk_in);
		update = 1'b1;
		@(negedge clk_in);
		update = 1'b0;
		if (en) begin
			active = shadow;	// all four at once
		end
	endtask

	// back to back blocks with one strobe per cycle
	task automatic run_blocks(input int count, input bit rnd, input int level);
		int          sum;
		logic [31:0] word;
		for (int b = 0; b < count; b++) begin
			sum = 0;
			for (int n = 0; n < (1 << os_log); n++) begin
				word = rnd ? next_random() : 32'(level);
				@(negedge clk_in);
				adc_data  = adc_sample_t'(word[w_adc-1:0]);
				adc_valid = 1'b1;
				sum += int'($signed(word[w_adc-1:0]));
			end
			mean_q.push_back(sum >>> os_log);	// floor of the mean
		end
	endtask

	task automatic drain();
		@(negedge clk_in);
		adc_valid = 1'b0;
		while (mean_q.size() != 0) begin
			@(negedge clk_in);
		end
		repeat (2) @(negedge clk_in);	// core back in idle
	endtask

	task automatic check_output();
		longint   err;
		longint   u_new;
		pid_out_t expected;
		if (mean_q.size() == 0) begin
			$display("pid_valid pulsed with no completed sample block pending");
			abort_run();
		end else begin
			err   = longint'(active[0]) - longint'(mean_q.pop_front());
			u_new = u_prev
				+ (longint'(active[1]) + longint'(active[2]) + longint'(active[3])) * err
				- (longint'(active[1]) + 2 * longint'(active[3])) * e_prev1
				+ longint'(active[3]) * e_prev2;
			if (u_new > out_max) begin
				u_new = out_max;	// held on the positive rail
				max_hits++;
			end else if (u_new < out_min) begin
				u_new = out_min;
				min_hits++;
			end
			expected = pid_out_t'(u_new);
			u_prev   = u_new;
			e_prev2  = e_prev1;
			e_prev1  = err;
			assert (pid_data === expected) else begin
				$display("** Error: pid_data = 0x%h, expected 0x%h", pid_data, expected);
				abort_run();
			end
		end
	endtask

	always @(negedge clk_in) begin
		if (reset_in === 1'b0 && pid_valid === 1'b1) begin
			check_output();
		end
	end

	// concurrent properties on the bound checker
	always @(negedge clk_in) begin
		if (dut_i.props_i.fail_count != 0) begin
			$display("a concurrent property on the DUT failed");
			abort_run();
		end
	end

	initial begin
		#(watchdog_ns);
		$display("timeout: the run did not finish within %0d ns", watchdog_ns);
		abort_run();
	end

	////////////////////////////////////////////////////////////////////////////
	// stimulus
	////////////////////////////////////////////////////////////////////////////

	initial begin
		clk_in    = 1'b0;
		reset_in  = 1'b1;
		adc_data  = '0;
		adc_valid = 1'b0;
		host_addr = addr_setpoint;
		host_data = '0;
		host_we   = 1'b0;
		update    = 1'b0;
		repeat (8) @(negedge clk_in);
		reset_in = 1'b0;
		run_blocks(n_init, 1'b1, 0);	// reset coefficients
		drain();
		host_write(addr_setpoint, 16'd100);
		host_write(addr_p_coef, 16'd20);
		host_write(addr_i_coef, 16'd5);
		host_write(addr_d_coef, 16'd7);
		pulse_update();	// ignored while the enable is 0
		run_blocks(n_gate, 1'b1, 0);
		drain();
		host_write(addr_update_en, 16'd1);
		pulse_update();
		run_blocks(n_gate, 1'b1, 0);
		drain();
		host_write(addr_setpoint, 16'hfb50);	// -1200
		host_write(addr_p_coef, 16'd41);
		host_write(addr_i_coef, 16'd9);
		host_write(addr_d_coef, 16'hfff1);	// -15
		pulse_update();
		run_blocks(n_random, 1'b1, 0);
		drain();
		host_write(addr_clear, 16'd0);	// next output is k1 * e only
		run_blocks(n_clear, 1'b1, 0);
		drain();
		host_write(addr_setpoint, 16'h7fff);	// full positive error
		host_write(addr_p_coef, 16'd0);
		host_write(addr_i_coef, 16'h7fff);
		host_write(addr_d_coef, 16'd0);
		pulse_update();
		host_write(addr_clear, 16'd0);
		run_blocks(n_sat, 1'b0, -32768);
		drain();
		host_write(addr_setpoint, 16'h8000);	// sign reversed
		pulse_update();
		host_write(addr_clear, 16'd0);
		run_blocks(n_sat, 1'b0, 32767);
		drain();
		if (max_hits > 0 && min_hits > 0 && dut_i.props_i.fail_count == 0) begin
			$display("*** TEST PASSED ***");
			$finish;
		end else begin
			$display("rail not reached or a property failed: upper hits %0d, lower hits %0d",
				max_hits, min_hits);
			abort_run();
		end
	end

endmodule : pid_lock_tb

`default_nettype wire

/* tb/pid_lock_props.sv */
`default_nettype none

module pid_lock_props #(
	parameter int OS_LOG       = 2,	// samples per block is 2^OS_LOG
	parameter int COMP_LATENCY = 1	// core compute cycles
) (
	input logic                      clk_in,
	input logic                      reset_in,
	input logic                      adc_valid,
	input host_regs_pkg::host_addr_t host_addr,
	input logic                      host_we,
	input logic                      clear,	// from the active parameter interface
	input logic                      pid_valid
);
	timeunit 1ns;
	timeprecision 100ps;

	import host_regs_pkg::*;

	logic [OS_LOG-1:0] strobe_cnt;	// adc strobes taken in the current block
	logic              reset_q;	// reset seen on the previous edge
	logic              clear_write;	// host write to the clear address
	int                fail_count = 0;	// properties failed so far

	assign clear_write = host_we && (host_addr == addr_clear);

	always_ff @(posedge clk_in) begin
		reset_q <= reset_in;
		if (reset_in) begin
			strobe_cnt <= '0;
		end else if (adc_valid) begin
			strobe_cnt <= strobe_cnt + 1'b1;	// wraps with the filter block
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// reset, output timing, clear pulse
	////////////////////////////////////////////////////////////////////////////

	quiet_in_reset: assert property (@(posedge clk_in)
		(reset_in && reset_q) |-> (!pid_valid && !clear))
		else begin
			fail_count++;
			$error("pid_valid or clear high while reset is held");
		end

	// last strobe of a block to the output strobe
	block_latency: assert property (@(posedge clk_in) disable iff (reset_in)
		(adc_valid && (strobe_cnt == '1)) |-> ##(COMP_LATENCY + 2) pid_valid)
		else begin
			fail_count++;
			$error("pid_valid missing after a completed sample block");
		end

	single_valid: assert property (@(posedge clk_in) disable iff (reset_in)
		pid_valid |=> !pid_valid)
		else begin
			fail_count++;
			$error("pid_valid high on two consecutive cycles");
		end

	clear_one_cycle: assert property (@(posedge clk_in) disable iff (reset_in)
		clear_write |=> clear ##1 !clear)
		else begin
			fail_count++;
			$error("clear is not a single cycle after a clear write");
		end

	clear_cause: assert property (@(posedge clk_in) disable iff (reset_in)
		clear |-> $past(clear_write))
		else begin
			fail_count++;
			$error("clear raised without a host write to the clear address");
		end

endmodule : pid_lock_props

bind pid_lock_top pid_lock_props #(
	.OS_LOG      (OS_LOG),
	.COMP_LATENCY(COMP_LATENCY)
) props_i (
	.clk_in   (clk_in),
	.reset_in (reset_in),
	.adc_valid(adc_valid),
	.host_addr(host_addr),
	.host_we  (host_we),
	.clear    (params_if.clear),
	.pid_valid(pid_valid)
);

`default_nettype wire

/* verilog/pid_lock_top.sv */
`default_nettype none

module pid_lock_top #(
	parameter int                   OS_LOG        = 2,	// 4 samples per block
	parameter int                   COMP_LATENCY  = 1,	// core compute cycles
	parameter pid_types_pkg::coef_t SETPOINT_INIT = 16'sd0,
	parameter pid_types_pkg::coef_t P_COEF_INIT   = 16'sd10,
	parameter pid_types_pkg::coef_t I_COEF_INIT   = 16'sd3,
	parameter pid_types_pkg::coef_t D_COEF_INIT   = 16'sd0
) (
	input  logic                       clk_in,
	input  logic                       reset_in,
	input  pid_types_pkg::adc_sample_t adc_data,	// raw adc sample
	input  logic                       adc_valid,	// sample strobe
	input  host_regs_pkg::host_addr_t  host_addr,	// host register select
	input  host_regs_pkg::host_word_t  host_data,	// host write data
	input  logic                       host_we,	// host write strobe
	input  logic                       update,	// apply shadows
	output pid_types_pkg::pid_out_t    pid_data,	// servo output
	output logic                       pid_valid	// output strobe
);
	import pid_types_pkg::*;

	adc_sample_t filt_data;	// block mean, filter to core
	logic        filt_valid;

	pid_param_if params_if ();	// active parameter set

	oversample_filter #(
		.OS_LOG(OS_LOG)
	) filter_i (
		.clk_in    (clk_in),
		.reset_in  (reset_in),
		.adc_data  (adc_data),
		.adc_valid (adc_valid),
		.filt_data (filt_data),
		.filt_valid(filt_valid)
	);

	pid_param_regs #(
		.SETPOINT_INIT(SETPOINT_INIT),
		.P_COEF_INIT  (P_COEF_INIT),
		.I_COEF_INIT  (I_COEF_INIT),
		.D_COEF_INIT  (D_COEF_INIT)
	) regs_i (
		.clk_in   (clk_in),
		.reset_in (reset_in),
		.host_addr(host_addr),
		.host_data(host_data),
		.host_we  (host_we),
		.update   (update),
		.params   (params_if.regs)
	);

	pid_core #(
		.COMP_LATENCY(COMP_LATENCY)
	) core_i (
		.clk_in    (clk_in),
		.reset_in  (reset_in),
		.filt_data (filt_data),
		.filt_valid(filt_valid),
		.params    (params_if.core),
		.pid_data  (pid_data),
		.pid_valid (pid_valid)
	);

endmodule : pid_lock_top

`default_nettype wire

/* verilog/pid_core.sv */
`default_nettype none

module pid_core #(
	parameter int COMP_LATENCY = 1	// cycles spent in compute, at least 1
) (
	input  logic                       clk_in,
	input  logic                       reset_in,
	input  pid_types_pkg::adc_sample_t filt_data,	// filtered sample
	input  logic                       filt_valid,	// sample strobe
	pid_param_if.core                  params,	// active setpoint, coefficients, clear
	output pid_types_pkg::pid_out_t    pid_data,	// clamped pid output
	output logic                       pid_valid	// high in st_send only
);
	import pid_types_pkg::*;

	localparam int w_err  = w_adc + 1;	// setpoint minus sample needs one more bit
	localparam int w_k    = w_coef + 2;	// -p - 2d needs two more bits
	localparam int w_prod = w_err + w_k;	// full product width
	localparam int w_cnt  = (COMP_LATENCY > 1) ? $clog2(COMP_LATENCY) : 1;

	localparam pid_out_t max_out = {1'b0, {(w_out-1){1'b1}}};	// largest positive
	localparam pid_out_t min_out = {1'b1, {(w_out-1){1'b0}}};	// most negative

	////////////////////////////////////////////////////////////////////////////
	// signals
	////////////////////////////////////////////////////////////////////////////

	adc_sample_t sample;	// latched input sample

	logic signed [w_err-1:0] e_cur;	// current error
	logic signed [w_err-1:0] e_prev1;	// error one sample back
	logic signed [w_err-1:0] e_prev2;	// error two samples back

	logic signed [w_k-1:0] k1;
	logic signed [w_k-1:0] k2;
	logic signed [w_k-1:0] k3;

	logic signed [w_prod-1:0] prod1;
	logic signed [w_prod-1:0] prod2;
	logic signed [w_prod-1:0] prod3;

	pid_out_t delta_u;	// velocity-form increment
	pid_out_t u_prev;	// last output sent
	pid_out_t u_cur;	// unclamped new output
	pid_out_t u_clamp;	// rail picked by the sign of u_prev
	logic     overflow;

	pid_state_t       state;
	pid_state_t       next_state;
	logic [w_cnt-1:0] counter;	// cycles spent in compute

	////////////////////////////////////////////////////////////////////////////
	// datapath
	////////////////////////////////////////////////////////////////////////////

	assign e_cur = w_err'(params.setpoint) - w_err'(sample);

	// z-transform coefficients
	assign k1 = w_k'(params.p_coef) + w_k'(params.i_coef) + w_k'(params.d_coef);
	assign k2 = -w_k'(params.p_coef) - (w_k'(params.d_coef) <<< 1);
	assign k3 = w_k'(params.d_coef);

	assign prod1 = w_prod'(k1) * w_prod'(e_cur);
	assign prod2 = w_prod'(k2) * w_prod'(e_prev1);
	assign prod3 = w_prod'(k3) * w_prod'(e_prev2);

	assign delta_u = w_out'(prod1) + w_out'(prod2) + w_out'(prod3);
	assign u_cur   = delta_u + u_prev;

	// same-sign operands giving an opposite-sign sum
	assign overflow = (delta_u[w_out-1] == u_prev[w_out-1])
		&& (u_cur[w_out-1] != u_prev[w_out-1]);
	assign u_clamp  = u_prev[w_out-1] ? min_out : max_out;

	assign pid_data  = overflow ? u_clamp : u_cur;
	assign pid_valid = (state == st_send);

	// samples outside st_idle are dropped
	always_ff @(posedge clk_in) begin
		if (filt_valid && (state == st_idle)) begin
			sample <= filt_data;
		end
	end

	// history, wiped by clear
	always_ff @(posedge clk_in) begin
		if (reset_in || params.clear) begin
			u_prev  <= '0;
			e_prev1 <= '0;
			e_prev2 <= '0;
		end else if (state == st_done) begin
			u_prev  <= pid_data;
			e_prev1 <= e_cur;
			e_prev2 <= e_prev1;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// sequencing FSM
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			state   <= st_idle;
			counter <= '0;
		end else begin
			state <= next_state;
			if ((state != st_compute) || (next_state != st_compute)) begin
				counter <= '0;	// restart on every state change
			end else begin
				counter <= counter + w_cnt'(1);
			end
		end
	end

	always_comb begin
		next_state = state;	// hold by default
		case (state)
			st_idle: begin
				if (filt_valid) begin
					next_state = st_compute;
				end
			end
			st_compute: begin
				if (counter == w_cnt'(COMP_LATENCY - 1)) begin
					next_state = st_send;
				end
			end
			st_send: next_state = st_done;
			st_done: next_state = st_idle;
			default: next_state = st_idle;
		endcase
	end

endmodule : pid_core

`default_nettype wire

/* verilog/pid_param_regs.sv */
`default_nettype none

module pid_param_regs #(
	parameter pid_types_pkg::coef_t SETPOINT_INIT = 16'sd0,	// active setpoint after reset
	parameter pid_types_pkg::coef_t P_COEF_INIT   = 16'sd10,	// active p after reset
	parameter pid_types_pkg::coef_t I_COEF_INIT   = 16'sd3,	// active i after reset
	parameter pid_types_pkg::coef_t D_COEF_INIT   = 16'sd0	// active d after reset
) (
	input  logic                      clk_in,
	input  logic                      reset_in,
	input  host_regs_pkg::host_addr_t host_addr,	// register select
	input  host_regs_pkg::host_word_t host_data,	// write data
	input  logic                      host_we,	// one-cycle write strobe
	input  logic                      update,	// shadow to active pulse
	pid_param_if.regs                 params	// active set to the core
);
	import pid_types_pkg::*;
	import host_regs_pkg::*;

	////////////////////////////////////////////////////////////////////////////
	// shadow registers, written by the host
	////////////////////////////////////////////////////////////////////////////

	coef_t sp_shadow;
	coef_t p_shadow;
	coef_t i_shadow;
	coef_t d_shadow;
	logic  update_en;	// arms the update pulse
	logic  clear_q;	// registered clear pulse

	// host data is as wide as a coefficient
	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			sp_shadow <= SETPOINT_INIT;
			p_shadow  <= P_COEF_INIT;
			i_shadow  <= I_COEF_INIT;
			d_shadow  <= D_COEF_INIT;
			update_en <= 1'b0;
			clear_q   <= 1'b0;
		end else begin
			clear_q <= host_we && (host_addr == addr_clear);	// high for one cycle
			if (host_we) begin
				case (host_addr)
					addr_setpoint:  sp_shadow <= coef_t'(host_data);
					addr_p_coef:    p_shadow  <= coef_t'(host_data);
					addr_i_coef:    i_shadow  <= coef_t'(host_data);
					addr_d_coef:    d_shadow  <= coef_t'(host_data);
					addr_update_en: update_en <= host_data[update_en_bit];
					default:        ;	// clear handled above
				endcase
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// active set
	////////////////////////////////////////////////////////////////////////////

	coef_t sp_act;
	coef_t p_act;
	coef_t i_act;
	coef_t d_act;

	// all four copied together, ignored while disabled
	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			sp_act <= SETPOINT_INIT;
			p_act  <= P_COEF_INIT;
			i_act  <= I_COEF_INIT;
			d_act  <= D_COEF_INIT;
		end else if (update && update_en) begin
			sp_act <= sp_shadow;
			p_act  <= p_shadow;
			i_act  <= i_shadow;
			d_act  <= d_shadow;
		end
	end

	assign params.setpoint = sp_act;
	assign params.p_coef   = p_act;
	assign params.i_coef   = i_act;
	assign params.d_coef   = d_act;
	assign params.clear    = clear_q;

endmodule : pid_param_regs

`default_nettype wire

/* verilog/oversample_filter.sv */
`default_nettype none

module oversample_filter #(
	parameter int OS_LOG = 2	// log2 of samples per block
) (
	input  logic                       clk_in,
	input  logic                       reset_in,
	input  pid_types_pkg::adc_sample_t adc_data,	// raw sample
	input  logic                       adc_valid,	// one strobe per sample
	output pid_types_pkg::adc_sample_t filt_data,	// block mean
	output logic                       filt_valid	// pulse per block
);
	import pid_types_pkg::*;

	localparam int w_acc = w_adc + OS_LOG;	// room for the full block sum

	////////////////////////////////////////////////////////////////////////////
	// accumulator
	////////////////////////////////////////////////////////////////////////////

	logic signed [w_acc-1:0] acc;	// running block sum
	logic signed [w_acc-1:0] acc_next;	// sum including the current sample
	logic signed [w_acc-1:0] mean_wide;	// sum / 2^OS_LOG, still wide
	logic [OS_LOG-1:0]       cnt;	// samples taken so far in the block
	logic                    last;	// current sample closes the block

	assign acc_next  = acc + w_acc'(adc_data);	// sign extended add
	assign mean_wide = acc_next >>> OS_LOG;	// floor division
	assign last      = (cnt == '1);

	// block sum and sample count
	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			acc        <= '0;
			cnt        <= '0;
			filt_valid <= 1'b0;
		end else begin
			filt_valid <= 1'b0;	// default low, single pulse
			if (adc_valid) begin
				cnt <= cnt + OS_LOG'(1);	// wraps to 0 after the last sample
				if (last) begin
					acc        <= '0;	// restart for the next block
					filt_valid <= 1'b1;
				end else begin
					acc <= acc_next;
				end
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// output sample
	////////////////////////////////////////////////////////////////////////////

	// mean fits the adc width by construction
	always_ff @(posedge clk_in) begin
		if (adc_valid && last) begin
			filt_data <= mean_wide[w_adc-1:0];
		end
	end

endmodule : oversample_filter

`default_nettype wire

/* verilog/pid_param_if.sv */
`default_nettype none

////////////////////////////////////////////////////////////////////////////
// active pid parameters from the register block to the core
////////////////////////////////////////////////////////////////////////////

interface pid_param_if;
	import pid_types_pkg::*;

	coef_t setpoint;	// active lock setpoint
	coef_t p_coef;	// proportional
	coef_t i_coef;	// integral
	coef_t d_coef;	// derivative
	logic  clear;	// one-cycle history wipe

	// register block side
	modport regs (
		output setpoint, p_coef, i_coef, d_coef, clear
	);

	// pid core side
	modport core (
		input setpoint, p_coef, i_coef, d_coef, clear
	);

endinterface : pid_param_if

`default_nettype wire

/* verilog/host_regs_pkg.sv */
`default_nettype none

////////////////////////////////////////////////////////////////////////////
// host register map
////////////////////////////////////////////////////////////////////////////

package host_regs_pkg;

	localparam int w_host = 16;	// host write word, same as the coefficient width

	typedef logic [w_host-1:0] host_word_t;	// host write data

	// register addresses, one opcode per host write target
	typedef enum logic [2:0] {
		addr_setpoint  = 3'd0,	// shadow setpoint
		addr_p_coef    = 3'd1,	// shadow p coefficient
		addr_i_coef    = 3'd2,	// shadow i coefficient
		addr_d_coef    = 3'd3,	// shadow d coefficient
		addr_update_en = 3'd4,	// bit 0 arms the update pulse
		addr_clear     = 3'd5	// any write clears pid history
	} host_addr_t;

	localparam int update_en_bit = 0;	// enable bit inside the addr_update_en word

endpackage : host_regs_pkg

`default_nettype wire

/* verilog/pid_types_pkg.sv */
`default_nettype none

////////////////////////////////////////////////////////////////////////////
// datapath widths and types shared by the filter and the PID core
////////////////////////////////////////////////////////////////////////////

package pid_types_pkg;

	// widths
	localparam int w_adc  = 16;	// raw adc word and filtered sample
	localparam int w_coef = 16;	// setpoint and p, i, d coefficients
	localparam int w_out  = 48;	// pid output accumulator, wide to keep clear of overflow

	// sample and coefficient words
	typedef logic signed [w_adc-1:0]  adc_sample_t;	// adc / filter sample
	typedef logic signed [w_coef-1:0] coef_t;	// setpoint or coefficient
	typedef logic signed [w_out-1:0]  pid_out_t;	// pid output word

	// core sequencing
	typedef enum logic [1:0] {
		st_idle,	// wait for a filtered sample
		st_compute,	// hold for the compute latency
		st_send,	// output valid this cycle
		st_done	// shift output and errors into history
	} pid_state_t;

endpackage : pid_types_pkg

`default_nettype wire
